// File: project.f
+incdir+tb
source/cu_pkg.sv
source/instr_decoder.sv
source/cu_sequencer.sv
source/ctrl_word_gen.sv
source/control_unit.sv
tb/control_unit_tb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - files:
      - source/cu_pkg.sv
      - source/instr_decoder.sv
      - source/cu_sequencer.sv
      - source/ctrl_word_gen.sv
      - source/control_unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/control_unit_tb.sv

// File: tb/control_unit_golden.txt
// records in hex: start opcode zflag cycles, then one word per cycle from fetch1 on
// word nibbles: write_en(4) read_en(4) mem_read alu_op flags, flags = mem_write pc_inc endop
10
0 000 0 4 00000000000 00000000000 00000000000 00000000000
1 000 0 5 00040002000 80000000202 000C8002000 00000000000 00010000060
0 003 0 5 00040002000 80000000202 000C8002000 00000000000 00010010020
0 004 0 5 00040002000 80000000202 000C8002000 00000000000 00010010030
0 002 0 5 00040002000 80000000202 000C8002000 00000000000 00010010040
0 005 0 5 00040002000 80000000202 000C8002000 00000000000 00010000050
0 00E 0 5 00040002000 80000000202 000C8002000 00000000000 00400001000
0 015 0 5 00040002000 80000000202 000C8002000 00000000000 00011000010
0 007 1 7 00040002000 80000000202 000C8002000 00000000000
    80000000202 00028000000 00040002000
0 007 0 6 00040002000 80000000202 000C8002000 00000000000 00000000002 00040002000
0 006 0 7 00040002000 80000000202 000C8002000 00000000000
    80000000202 00028000000 00040002000
0 001 0 9 00040002000 80000000202 000C8002000 00000000000
    80000000200 00048000000 00000000002 80000000100 00018000010
0 01E 0 7 00040002000 80000000202 000C8002000 00000000000
    00042000000 80000001004 00040002004
0 01F 0 8 00040002000 80000000202 000C8002000 00000000000
    00040001000 00040002000 80000000100 00018000010
0 020 0 6 00040002000 80000000202 000C8002000 00000000000 00000000001 00000000000
1 028 0 6 00040002000 80000000202 000C8002000 00000000000 00000000000 00000000000

// File: tb/control_unit_checks.svh
`ifndef control_unit_checks_svh
`define control_unit_checks_svh

task automatic check_ctrl(
    input ctrl_word_t actual,
    input ctrl_word_t expected,
    input int         rec,
    input int         cyc
);
    if (actual !== expected)
    begin
        ctrl_errors++;
        $display("ERROR at %0t: record %0d cycle %0d ctrl %h, expected %h",
                 $time, rec, cyc, actual, expected);
    end
endtask

// endop_signal must be high only in the endop1 cycle
task automatic check_endop(
    input logic actual,
    input logic expected,
    input int   rec,
    input int   cyc
);
    if (actual !== expected)
    begin
        endop_errors++;
        $display("ERROR at %0t: record %0d cycle %0d endop_signal %b, expected %b",
                 $time, rec, cyc, actual, expected);
    end
endtask

`endif

// File: tb/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb;
    import cu_pkg::*;

    localparam int golden_depth = 256;

    logic                        clk;
    logic                        reset;
    logic                        start;
    logic                        zflag;
    logic [ir_width_default-1:0] opcode;
    ctrl_word_t                  ctrl;
    logic                        endop_signal;

    logic [43:0] golden [0:golden_depth-1];
    int          num_records;
    int          cycle_limit;
    int          cycle_count;
    int          ctrl_errors;
    int          endop_errors;

    `include "control_unit_checks.svh"

    control_unit #(
        .ir_width (ir_width_default)
    ) control_unit_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .zflag        (zflag),
        .opcode       (opcode),
        .ctrl         (ctrl),
        .endop_signal (endop_signal)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // each field of a golden word starts on a nibble boundary
    function automatic ctrl_word_t word_to_ctrl(input logic [43:0] word);
        ctrl_word_t c;
        c.write_en  = word[43:28];
        c.read_en   = word[27:12];
        c.mem_read  = mem_sel_e'(word[9:8]);
        c.mem_write = word[2];
        c.alu_op    = alu_op_e'(word[6:4]);
        c.pc_inc    = word[1];
        return c;
    endfunction

    function automatic int total_cycles();
        int idx;
        int rec;
        int sum;
        idx = 1;
        sum = 0;
        for (rec = 0; rec < num_records; rec++)
        begin
            sum += int'(golden[idx+3][7:0]);
            idx += 4 + int'(golden[idx+3][7:0]);
        end
        return sum;
    endfunction

    // called on a falling edge and each record starts on the edge where the last check ran
    task automatic run_records();
        int idx;
        int rec;
        int cyc;
        int count;
        idx = 1;
        for (rec = 0; rec < num_records; rec++)
        begin
            start  = golden[idx][0];
            opcode = golden[idx+1][ir_width_default-1:0];
            zflag  = golden[idx+2][0];
            count  = int'(golden[idx+3][7:0]);
            idx += 4;
            for (cyc = 0; cyc < count; cyc++)
            begin
                @(negedge clk);
                check_ctrl(ctrl, word_to_ctrl(golden[idx+cyc]), rec, cyc);
                check_endop(endop_signal, golden[idx+cyc][0], rec, cyc);
                start = 1'b0;   // start only counts in idle
            end
            idx += count;
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        zflag        = 1'b0;
        opcode       = '0;
        cycle_count  = 0;
        cycle_limit  = 20;
        ctrl_errors  = 0;
        endop_errors = 0;
        $readmemh("tb/control_unit_golden.txt", golden);
        if ($isunknown(golden[0]) || golden[0] == '0)
        begin
            $display("the golden file tb/control_unit_golden.txt is missing or holds no records");
            $display("TESTBENCH FAILED");
        end
        else
        begin
            num_records = int'(golden[0][7:0]);
            cycle_limit = total_cycles() + 20;
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            run_records();
            $display("ctrl errors: %0d, endop errors: %0d", ctrl_errors, endop_errors);
            if (ctrl_errors == 0 && endop_errors == 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: source/control_unit.sv
`timescale 1ns/1ps

module control_unit #(
    parameter int ir_width = cu_pkg::ir_width_default
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                zflag,
    input  logic [ir_width-1:0] opcode,
    output cu_pkg::ctrl_word_t  ctrl,
    output logic                endop_signal
);
    import cu_pkg::*;

    decoded_instr_t instr;
    cu_state_e      state;

    instr_decoder #(
        .ir_width (ir_width)
    ) instr_decoder_inst (
        .opcode (opcode),
        .instr  (instr)
    );

    cu_sequencer cu_sequencer_inst (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .zflag (zflag),
        .instr (instr),
        .state (state)
    );

    // control outputs follow the state in the same cycle
    ctrl_word_gen ctrl_word_gen_inst (
        .state        (state),
        .instr        (instr),
        .ctrl         (ctrl),
        .endop_signal (endop_signal)
    );

endmodule

// File: source/ctrl_word_gen.sv
`timescale 1ns/1ps

module ctrl_word_gen (
    input  cu_pkg::cu_state_e      state,
    input  cu_pkg::decoded_instr_t instr,
    output cu_pkg::ctrl_word_t     ctrl,
    output logic                   endop_signal
);
    import cu_pkg::*;

    localparam ctrl_word_t ctrl_idle = '{sel_none, sel_none, mem_none, 1'b0, alu_idle, 1'b0};

    reg_sel_t target_sel;

    assign target_sel = reg_sel_t'(1) << instr.target;   // one-hot of the move target

    assign endop_signal = (state == st_endop1);

    // words are written as write, read, mem_read, mem_write, alu, pc_inc
    always_comb
    begin
        ctrl = ctrl_idle;
        case (state)
            st_idle,
            st_fetch4,
            st_endop1:
                ctrl = ctrl_idle;

            // copy pc into ar so the next fetch sees the right address
            st_fetch1,
            st_jump3,
            st_jumpzy3,
            st_jumpzn2,
            st_load_reg2:
                ctrl = '{sel_ar, sel_pc, mem_none, 1'b0, alu_idle, 1'b0};

            // instruction word into dr, pc steps past it
            st_fetch2,
            st_jump1,
            st_jumpzy1:
                ctrl = '{sel_dr, sel_none, mem_ins, 1'b0, alu_idle, 1'b1};

            st_fetch3:
                ctrl = '{sel_ir | sel_ar, sel_dr | sel_pc, mem_none, 1'b0, alu_idle, 1'b0};

            st_clr1: ctrl = '{sel_ac, sel_none, mem_none, 1'b0, alu_zero, 1'b0};
            st_inc1: ctrl = '{sel_ac, sel_none, mem_none, 1'b0, alu_plus1, 1'b0};
            st_mul1: ctrl = '{sel_ac, sel_r, mem_none, 1'b0, alu_mul, 1'b0};
            st_add1: ctrl = '{sel_ac, sel_r, mem_none, 1'b0, alu_add, 1'b0};
            st_sub1: ctrl = '{sel_ac, sel_r, mem_none, 1'b0, alu_sub, 1'b0};

            st_load1: ctrl = '{sel_dr, sel_none, mem_ins, 1'b0, alu_idle, 1'b0};
            st_load2: ctrl = '{sel_ar, sel_dr, mem_none, 1'b0, alu_idle, 1'b0};

            st_load3,
            st_jumpzn1:
                ctrl = '{sel_none, sel_none, mem_none, 1'b0, alu_idle, 1'b1};

            // dr takes its value from data memory here
            st_load4,
            st_load_reg3:
                ctrl = '{sel_dr, sel_none, mem_data, 1'b0, alu_idle, 1'b0};

            st_load5,
            st_load_reg4:
                ctrl = '{sel_ac, sel_dr, mem_none, 1'b0, alu_pass, 1'b0};

            st_jump2,
            st_jumpzy2:
                ctrl = '{sel_pc, sel_dr, mem_none, 1'b0, alu_idle, 1'b0};

            st_mvac1: ctrl = '{target_sel, sel_ac, mem_none, 1'b0, alu_idle, 1'b0};
            st_mov1:  ctrl = '{sel_ac, target_sel, mem_none, 1'b0, alu_pass, 1'b0};

            st_store1: ctrl = '{sel_ar, sel_gammap, mem_none, 1'b0, alu_idle, 1'b0};
            st_store2: ctrl = '{sel_dr, sel_ac, mem_none, 1'b1, alu_idle, 1'b0};
            st_store3: ctrl = '{sel_ar, sel_pc, mem_none, 1'b1, alu_idle, 1'b0};

            st_load_reg1: ctrl = '{sel_ar, sel_ac, mem_none, 1'b0, alu_idle, 1'b0};

            default: ctrl = ctrl_idle;
        endcase
    end

endmodule

// File: source/cu_sequencer.sv
`timescale 1ns/1ps

module cu_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   zflag,
    input  cu_pkg::decoded_instr_t instr,
    output cu_pkg::cu_state_e      state
);
    import cu_pkg::*;

    cu_state_e next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = st_idle;
        case (state)
            st_idle:   next_state = start ? st_fetch1 : st_idle;
            st_fetch1: next_state = st_fetch2;
            st_fetch2: next_state = st_fetch3;
            st_fetch3: next_state = st_fetch4;

            // ir is stable by now, dispatch on the decoded instruction
            st_fetch4:
            begin
                case (instr.kind)
                    kind_clr:      next_state = st_clr1;
                    kind_load:     next_state = st_load1;
                    kind_mul:      next_state = st_mul1;
                    kind_add:      next_state = st_add1;
                    kind_sub:      next_state = st_sub1;
                    kind_inc:      next_state = st_inc1;
                    kind_jump:     next_state = st_jump1;
                    kind_jumpz:    next_state = zflag ? st_jumpzy1 : st_jumpzn1;
                    kind_mvac:     next_state = st_mvac1;
                    kind_mov:      next_state = st_mov1;
                    kind_store:    next_state = st_store1;
                    kind_load_reg: next_state = st_load_reg1;
                    kind_endop:    next_state = st_endop1;
                    default:       next_state = st_idle;
                endcase
            end

            st_load1: next_state = st_load2;
            st_load2: next_state = st_load3;
            st_load3: next_state = st_load4;   // address settles in data memory
            st_load4: next_state = st_load5;

            st_jump1:   next_state = st_jump2;
            st_jump2:   next_state = st_jump3;
            st_jumpzy1: next_state = st_jumpzy2;
            st_jumpzy2: next_state = st_jumpzy3;
            st_jumpzn1: next_state = st_jumpzn2;  // skip over the branch address

            st_store1: next_state = st_store2;
            st_store2: next_state = st_store3;

            st_load_reg1: next_state = st_load_reg2;
            st_load_reg2: next_state = st_load_reg3;
            st_load_reg3: next_state = st_load_reg4;

            // last step of every execute chain goes back for the next word
            st_clr1,
            st_mul1,
            st_add1,
            st_sub1,
            st_inc1,
            st_mvac1,
            st_mov1,
            st_load5,
            st_jump3,
            st_jumpzy3,
            st_jumpzn2,
            st_store3,
            st_load_reg4:
                next_state = st_fetch1;

            st_endop1: next_state = st_idle;
            default:   next_state = st_idle;
        endcase
    end

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder #(
    parameter int ir_width = cu_pkg::ir_width_default
) (
    input  logic [ir_width-1:0]    opcode,
    output cu_pkg::decoded_instr_t instr
);
    import cu_pkg::*;

    opcode_e op;

    // both move ranges list their registers in the same order
    function automatic reg_id_e move_target(input logic [5:0] offset);
        reg_id_e id;
        case (offset)
            6'd0:    id = reg_total;
            6'd1:    id = reg_alphap;
            6'd2:    id = reg_betap;
            6'd3:    id = reg_gammap;
            6'd4:    id = reg_r;
            6'd5:    id = reg_row;
            6'd6:    id = reg_cat;
            6'd7:    id = reg_cb;
            6'd8:    id = reg_rnow;
            6'd9:    id = reg_catnow;
            default: id = reg_cbnow;
        endcase
        return id;
    endfunction

    assign op = opcode_e'(opcode[5:0]);

    always_comb
    begin
        instr.kind   = kind_invalid;   // anything above endop stays invalid
        instr.target = reg_ac;
        if (opcode <= ir_width'(op_endop))
        begin
            case (op)
                op_clr:      instr.kind = kind_clr;
                op_load:     instr.kind = kind_load;
                op_mul:      instr.kind = kind_mul;
                op_add:      instr.kind = kind_add;
                op_sub:      instr.kind = kind_sub;
                op_inc:      instr.kind = kind_inc;
                op_jump:     instr.kind = kind_jump;
                op_jumpz:    instr.kind = kind_jumpz;
                op_store:    instr.kind = kind_store;
                op_load_reg: instr.kind = kind_load_reg;
                op_endop:    instr.kind = kind_endop;
                default:
                begin
                    // only the two move ranges are left here
                    if (op <= op_mvac_cbnow)
                    begin
                        instr.kind   = kind_mvac;
                        instr.target = move_target(6'(op - op_mvac_total));
                    end
                    else
                    begin
                        instr.kind   = kind_mov;
                        instr.target = move_target(6'(op - op_mov_total));
                    end
                end
            endcase
        end
    end

endmodule

// File: source/cu_pkg.sv
package cu_pkg;

    localparam int ir_width_default = 12;
    localparam int reg_count = 16;

    // one-hot select on the register bus, all zero selects nothing
    typedef logic [reg_count-1:0] reg_sel_t;

    // bit position of each register on the select bus
    typedef enum logic [3:0] {
        reg_ac, reg_pc, reg_ar, reg_ir,
        reg_r, reg_row, reg_cat, reg_cb,
        reg_rnow, reg_catnow, reg_cbnow,
        reg_alphap, reg_betap, reg_gammap,
        reg_total, reg_dr
    } reg_id_e;

    localparam reg_sel_t sel_none   = '0;
    localparam reg_sel_t sel_ac     = reg_sel_t'(1) << reg_ac;
    localparam reg_sel_t sel_pc     = reg_sel_t'(1) << reg_pc;
    localparam reg_sel_t sel_ar     = reg_sel_t'(1) << reg_ar;
    localparam reg_sel_t sel_ir     = reg_sel_t'(1) << reg_ir;
    localparam reg_sel_t sel_r      = reg_sel_t'(1) << reg_r;
    localparam reg_sel_t sel_gammap = reg_sel_t'(1) << reg_gammap;
    localparam reg_sel_t sel_dr     = reg_sel_t'(1) << reg_dr;

    typedef enum logic [5:0] {
        op_clr, op_load, op_mul, op_add, op_sub, op_inc, op_jump, op_jumpz,
        // accumulator to register, opcodes 8 to 18
        op_mvac_total, op_mvac_alphap, op_mvac_betap, op_mvac_gammap,
        op_mvac_r, op_mvac_row, op_mvac_cat, op_mvac_cb,
        op_mvac_rnow, op_mvac_catnow, op_mvac_cbnow,
        // register to accumulator, opcodes 19 to 29
        op_mov_total, op_mov_alphap, op_mov_betap, op_mov_gammap,
        op_mov_r, op_mov_row, op_mov_cat, op_mov_cb,
        op_mov_rnow, op_mov_catnow, op_mov_cbnow,
        op_store, op_load_reg, op_endop
    } opcode_e;

    typedef enum logic [3:0] {
        kind_clr, kind_load, kind_mul, kind_add, kind_sub, kind_inc,
        kind_jump, kind_jumpz, kind_mvac, kind_mov, kind_store,
        kind_load_reg, kind_endop, kind_invalid
    } instr_kind_e;

    typedef struct packed {
        instr_kind_e kind;
        reg_id_e     target;   // only meaningful for mvac and mov
    } decoded_instr_t;

    typedef enum logic [2:0] {
        alu_idle  = 3'd0,
        alu_pass  = 3'd1,
        alu_add   = 3'd2,
        alu_sub   = 3'd3,
        alu_mul   = 3'd4,
        alu_plus1 = 3'd5,
        alu_zero  = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none = 2'd0,
        mem_data = 2'd1,
        mem_ins  = 2'd2
    } mem_sel_e;

    typedef enum logic [5:0] {
        st_idle, st_fetch1, st_fetch2, st_fetch3, st_fetch4,
        st_clr1, st_load1, st_load2, st_load3, st_load4, st_load5,
        st_mul1, st_add1, st_sub1, st_inc1,
        st_jump1, st_jump2, st_jump3,
        st_jumpzy1, st_jumpzy2, st_jumpzy3, st_jumpzn1, st_jumpzn2,
        st_mvac1, st_mov1, st_store1, st_store2, st_store3,
        st_load_reg1, st_load_reg2, st_load_reg3, st_load_reg4,
        st_endop1
    } cu_state_e;

    typedef struct packed {
        reg_sel_t write_en;
        reg_sel_t read_en;
        mem_sel_e mem_read;
        logic     mem_write;
        alu_op_e  alu_op;
        logic     pc_inc;
    } ctrl_word_t;

endpackage
